//--- verilog.f
src/dcachePkg.sv
src/dcacheWayIf.sv
src/dcacheWordCounter.sv
src/dcacheWayMemory.sv
src/dcacheDatapath.sv
src/dcacheController.sv
src/dcacheTop.sv
tests/tbDcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - src/dcachePkg.sv
  - src/dcacheWayIf.sv
  - src/dcacheWordCounter.sv
  - src/dcacheWayMemory.sv
  - src/dcacheDatapath.sv
  - src/dcacheController.sv
  - src/dcacheTop.sv
  - target: test
    files:
      - tests/tbDcache.sv

//--- tests/tbDcache.sv
// Random stimulus testbench for the two way write back data cache
// Bus memory model plus a reference model of tags, LRU and the memory image
`timescale 1ns/1ps

module tbDcache;
    localparam int LINES = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int MAX_WAIT = 200;

    logic clk;
    logic rstN;
    logic enable;
    logic memWrite;
    logic memRead;
    logic invalidate;
    logic busReady;
    dcachePkg::word_t addr;
    dcachePkg::word_t wd;
    dcachePkg::word_t hrData;
    dcachePkg::byteMask_t byteMask;
    dcachePkg::word_t rd;
    dcachePkg::word_t hAddr;
    dcachePkg::word_t hwData;
    logic stall;
    logic hRequest;
    logic hWrite;

    // Word index is address bits 7:2, tags 1 to 3 only
    dcachePkg::word_t busMem [64];
    dcachePkg::word_t image [64];

    // Reference tag store
    logic [25:0] mTag [2][LINES];
    logic mValid [2][LINES];
    logic mDirty [2][LINES];
    logic mLru [LINES];

    // Pending miss
    logic inMiss;
    logic [25:0] wbTag;
    logic [25:0] reqTag;
    logic [1:0] curSet;
    int wbBeats;
    int rfBeats;

    // Outputs seen just before the last rising edge
    logic sStall;
    logic sHRequest;
    dcachePkg::word_t sRd;

    integer seed;
    int lowLeft;
    int valueErrors;
    int levelErrors;
    int otherErrors;
    logic timedOut;

    dcacheTop #(.LINES(LINES), .BLOCK_WORDS(BLOCK_WORDS)) dut_i (
        .clk, .rstN, .enable, .memWrite, .memRead, .invalidate, .busReady,
        .addr, .wd, .hrData, .byteMask, .rd, .hAddr, .hwData,
        .stall, .hRequest, .hWrite
    );

    always #10 clk = ~clk;

    function automatic dcachePkg::word_t lineAddr(input int tag, input int set, input int word);
        return {tag[25:0], set[1:0], word[1:0], 2'b00};
    endfunction

    // 12 words over sets 1 and 2, three tags each
    function automatic dcachePkg::word_t pickAddr(input int pick);
        return lineAddr(1 + pick % 3, 1 + (pick / 3) % 2, (pick / 6) * 3);
    endfunction

    function automatic dcachePkg::word_t mergeBytes(input dcachePkg::word_t old,
            input dcachePkg::word_t data, input dcachePkg::byteMask_t mask);
        dcachePkg::word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic checkWord(input string name, input dcachePkg::word_t got,
                             input dcachePkg::word_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            levelErrors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // One completed bus beat, checked against the pending miss
    task automatic observeBeat();
        dcachePkg::word_t expAddr;
        if (!inMiss) begin
            otherErrors++;
            $display("%0t bus beat completed with no miss pending", $time);
        end else if (hWrite) begin
            if (rfBeats != 0) begin
                otherErrors++;
                $display("%0t writeback beat after the refill had started", $time);
            end
            expAddr = lineAddr(wbTag, curSet, wbBeats);
            checkWord("hAddr", hAddr, expAddr);
            checkWord("hwData", hwData, image[expAddr[7:2]]);
            busMem[hAddr[7:2]] = hwData;
            wbBeats++;
        end else begin
            expAddr = lineAddr(reqTag, curSet, rfBeats);
            checkWord("hAddr", hAddr, expAddr);
            // Requested word reaches rd as it arrives
            if (expAddr == addr) begin
                checkWord("rd", rd, image[expAddr[7:2]]);
            end
            rfBeats++;
        end
    endtask

    // Ready with random low stretches, read data for the current address
    task automatic driveBus();
        if (lowLeft > 0) begin
            busReady = 1'b0;
            lowLeft--;
        end else if ($unsigned($random(seed)) % 4 == 0) begin
            busReady = 1'b0;
            lowLeft = $unsigned($random(seed)) % 5;
        end else begin
            busReady = 1'b1;
        end
        hrData = busMem[hAddr[7:2]];
    endtask

    // Sample at the rising edge, drive at the falling edge
    task automatic stepClock();
        @(posedge clk);
        sStall = stall;
        sHRequest = hRequest;
        sRd = rd;
        if (hRequest && busReady) begin
            observeBeat();
        end
        @(negedge clk);
        driveBus();
    endtask

    task automatic reportTimeout();
        dcachePkg::ctrlState_t st;
        st = dut_i.ctrl_i.state;
        otherErrors++;
        timedOut = 1'b1;
        $display("%0t stall did not fall within %0d cycles, controller in %s",
                 $time, MAX_WAIT, st.name());
    endtask

    task automatic doAccess(input dcachePkg::word_t a, input logic isWrite,
                            input dcachePkg::word_t data, input dcachePkg::byteMask_t mask);
        logic [1:0] set;
        logic [25:0] tag;
        logic hit;
        int way;
        int waited;
        int wbExpected;
        if (timedOut) begin
            return;
        end
        set = a[5:4];
        tag = a[31:6];
        hit = 1'b0;
        way = 0;
        wbExpected = 0;
        for (int w = 0; w < 2; w++) begin
            if (mValid[w][set] && mTag[w][set] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            // Empty way first, else least recently used
            way = !mValid[0][set] ? 0 : !mValid[1][set] ? 1 : int'(mLru[set]);
            wbExpected = (mValid[way][set] && mDirty[way][set]) ? BLOCK_WORDS : 0;
            inMiss = 1'b1;
            wbTag = mTag[way][set];
            reqTag = tag;
            curSet = set;
            wbBeats = 0;
            rfBeats = 0;
        end
        enable = 1'b1;
        addr = a;
        wd = data;
        byteMask = mask;
        memWrite = isWrite;
        memRead = !isWrite;
        stepClock();
        checkLevel("stall", sStall, !hit);
        if (!hit) begin
            waited = 0;
            while (sStall && waited < MAX_WAIT) begin
                stepClock();
                waited++;
            end
            inMiss = 1'b0;
            if (sStall) begin
                reportTimeout();
                return;
            end
            if (wbBeats != wbExpected || rfBeats != BLOCK_WORDS) begin
                otherErrors++;
                $display("%0t miss to %h made %0d writeback and %0d refill beats, not %0d and %0d",
                         $time, a, wbBeats, rfBeats, wbExpected, BLOCK_WORDS);
            end
            mTag[way][set] = tag;
            mValid[way][set] = 1'b1;
            mDirty[way][set] = 1'b0;
        end
        if (isWrite) begin
            image[a[7:2]] = mergeBytes(image[a[7:2]], data, mask);
            mDirty[way][set] = 1'b1;
        end else begin
            checkWord("rd", sRd, image[a[7:2]]);
        end
        mLru[set] = (way == 0);
    endtask

    task automatic idleCycle();
        enable = 1'b1;
        memRead = 1'b0;
        memWrite = 1'b0;
        addr = $random(seed);
        stepClock();
        checkLevel("stall", sStall, 1'b0);
    endtask

    // All lines dropped, dirty data lost, memory image falls back to the bus memory
    task automatic invalidateAll();
        memRead = 1'b0;
        memWrite = 1'b0;
        invalidate = 1'b1;
        stepClock();
        invalidate = 1'b0;
        checkLevel("stall", sStall, 1'b0);
        for (int s = 0; s < LINES; s++) begin
            for (int w = 0; w < 2; w++) begin
                mValid[w][s] = 1'b0;
                mDirty[w][s] = 1'b0;
            end
        end
        for (int i = 0; i < 64; i++) begin
            image[i] = busMem[i];
        end
    endtask

    task automatic disabledCycle();
        enable = 1'b0;
        memRead = 1'($random(seed));
        memWrite = 1'($random(seed));
        addr = pickAddr($unsigned($random(seed)) % 12);
        wd = $random(seed);
        byteMask = 4'($random(seed));
        stepClock();
        checkLevel("stall", sStall, 1'b0);
        checkLevel("hRequest", sHRequest, 1'b0);
        checkWord("rd", sRd, wd);
    endtask

    initial begin
        int kind;
        int pick;
        seed = 32'h5563_3e1d;
        clk = 1'b0;
        rstN = 1'b0;
        enable = 1'b0;
        memWrite = 1'b0;
        memRead = 1'b0;
        invalidate = 1'b0;
        busReady = 1'b0;
        addr = '0;
        wd = '0;
        hrData = '0;
        byteMask = '0;
        valueErrors = 0;
        levelErrors = 0;
        otherErrors = 0;
        lowLeft = 0;
        timedOut = 1'b0;
        inMiss = 1'b0;
        for (int i = 0; i < 64; i++) begin
            busMem[i] = 32'h1357_2468 ^ (i * 32'h9e37_79b9);
            image[i] = busMem[i];
        end
        for (int s = 0; s < LINES; s++) begin
            mLru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                mTag[w][s] = '0;
                mValid[w][s] = 1'b0;
                mDirty[w][s] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        enable = 1'b1;
        stepClock();
        checkLevel("stall", sStall, 1'b0);
        checkLevel("hRequest", sHRequest, 1'b0);
        checkLevel("hWrite", hWrite, 1'b0);

        // Three tags rotating through set 1, victims show in the writeback address
        doAccess(pickAddr(0), 1'b1, 32'haaaa_0001, 4'hf);
        doAccess(pickAddr(1), 1'b1, 32'hbbbb_0002, 4'hf);
        doAccess(pickAddr(0), 1'b0, '0, '0);
        doAccess(pickAddr(2), 1'b1, 32'hcccc_0003, 4'b0101);
        doAccess(pickAddr(1), 1'b0, '0, '0);
        doAccess(pickAddr(2), 1'b0, '0, '0);

        // Dirty word lost by invalidate
        doAccess(pickAddr(9), 1'b1, 32'hdead_beef, 4'hf);
        doAccess(pickAddr(9), 1'b0, '0, '0);
        invalidateAll();
        doAccess(pickAddr(9), 1'b0, '0, '0);

        repeat (8) disabledCycle();

        for (int n = 0; n < 400 && !timedOut; n++) begin
            kind = $unsigned($random(seed)) % 32;
            pick = $unsigned($random(seed)) % 12;
            if (kind == 0) begin
                invalidateAll();
            end else if (kind < 8) begin
                idleCycle();
            end else if (kind < 20) begin
                doAccess(pickAddr(pick), 1'b0, $random(seed), 4'($random(seed)));
            end else begin
                doAccess(pickAddr(pick), 1'b1, $random(seed), 4'($random(seed)));
            end
        end

        $display("errors: %0d value, %0d level, %0d other",
                 valueErrors, levelErrors, otherErrors);
        if (valueErrors + levelErrors + otherErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src/dcacheTop.sv
// Two way set associative write back data cache
// Connects controller, beat counter, way memory and datapath
`timescale 1ns/1ps

module dcacheTop #(
    parameter int LINES = 8,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 enable,
    input  logic                 memWrite,
    input  logic                 memRead,
    input  logic                 invalidate,
    input  logic                 busReady,
    input  dcachePkg::word_t     addr,
    input  dcachePkg::word_t     wd,
    input  dcachePkg::word_t     hrData,
    input  dcachePkg::byteMask_t byteMask,
    output dcachePkg::word_t     rd,
    output dcachePkg::word_t     hAddr,
    output dcachePkg::word_t     hwData,
    output logic                 stall,
    output logic                 hRequest,
    output logic                 hWrite
);
    // Controller to datapath selects
    logic useCacheAddr;
    logic fromBus;

    // Beat counter handshake
    logic cntClear;
    logic cntStep;
    logic cntLast;
    logic [$clog2(BLOCK_WORDS)-1:0] cntValue;

    dcacheWayIf #(.LINES(LINES), .BLOCK_WORDS(BLOCK_WORDS)) wayBus ();

    dcacheController #(.LINES(LINES), .BLOCK_WORDS(BLOCK_WORDS)) ctrl_i (
        .clk, .rstN, .enable, .memWrite, .memRead, .invalidate, .busReady,
        .addr, .stall, .hRequest, .hWrite, .useCacheAddr, .fromBus,
        .cntClear, .cntStep, .cntLast, .cntValue, .wayBus(wayBus.ctrl)
    );

    dcacheWordCounter #(.BLOCK_WORDS(BLOCK_WORDS)) counter_i (
        .clk, .rstN, .clear(cntClear), .step(cntStep), .value(cntValue), .last(cntLast)
    );

    dcacheWayMemory #(.LINES(LINES), .BLOCK_WORDS(BLOCK_WORDS)) mem_i (
        .clk, .rstN, .invalidate, .wayBus(wayBus.mem)
    );

    // Merged word feeds the way write port
    dcacheDatapath #(.LINES(LINES), .BLOCK_WORDS(BLOCK_WORDS)) data_i (
        .addr, .wd, .hrData, .byteMask, .useCacheAddr, .fromBus, .memWrite,
        .cntValue, .wayBus(wayBus.data), .rd, .hAddr, .hwData,
        .mergedWord(wayBus.wrData)
    );

endmodule

//--- src/dcacheController.sv
// Data cache controller
// Hit detection and the writeback and refill miss sequence
`timescale 1ns/1ps

module dcacheController #(
    parameter int LINES = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           enable,
    input  logic                           memWrite,
    input  logic                           memRead,
    input  logic                           invalidate,
    input  logic                           busReady,
    input  dcachePkg::word_t               addr,
    output logic                           stall,
    output logic                           hRequest,
    output logic                           hWrite,
    output logic                           useCacheAddr,
    output logic                           fromBus,
    output logic                           cntClear,
    output logic                           cntStep,
    input  logic                           cntLast,
    input  logic [$clog2(BLOCK_WORDS)-1:0] cntValue,
    dcacheWayIf.ctrl                       wayBus
);
    localparam int setBits = $clog2(LINES);
    localparam int offsetBits = $clog2(BLOCK_WORDS);
    localparam int tagBits = dcachePkg::WORD_BITS - setBits - offsetBits
                             - dcachePkg::BYTE_OFFSET_BITS;

    dcachePkg::ctrlState_t state;
    dcachePkg::ctrlState_t nextState;

    // Way chosen for eviction, held for the whole miss
    logic fillWay;
    logic access;
    logic hitAny;
    logic takeHit;

    // Fields of the current access
    logic [tagBits-1:0] addrTag;
    logic [setBits-1:0] addrSet;
    logic [offsetBits-1:0] addrOff;

    assign addrTag = addr[dcachePkg::WORD_BITS-1 -: tagBits];
    assign addrSet = addr[dcachePkg::BYTE_OFFSET_BITS + offsetBits +: setBits];
    assign addrOff = addr[dcachePkg::BYTE_OFFSET_BITS +: offsetBits];

    assign access = enable && (memRead || memWrite);
    assign hitAny = |wayBus.hit;

    // Lookup always targets the set of the held access
    assign wayBus.setIdx = addrSet;
    assign wayBus.newTag = addrTag;
    assign wayBus.newValid = 1'b1;
    assign wayBus.bypass = !enable;
    assign wayBus.ctrlIdle = (state == dcachePkg::IDLE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= dcachePkg::IDLE;
            fillWay <= 1'b0;
        end else begin
            state <= nextState;
            // Latch victim before refill beats change the valid bits
            if (state == dcachePkg::IDLE && stall) begin
                fillWay <= wayBus.victimWay;
            end
        end
    end

    always_comb begin
        nextState = state;
        stall = 1'b0;
        hRequest = 1'b0;
        hWrite = 1'b0;
        useCacheAddr = 1'b0;
        fromBus = 1'b0;
        cntClear = 1'b0;
        cntStep = 1'b0;
        takeHit = 1'b0;
        wayBus.wordOff = addrOff;
        wayBus.waySel = wayBus.hit[1];
        wayBus.writeEn = 1'b0;
        wayBus.lineFill = 1'b0;
        wayBus.newDirty = 1'b0;
        wayBus.lruUpdate = 1'b0;

        case (state)
            dcachePkg::IDLE: begin
                // Invalidate takes the cycle, access waits
                if (access && !invalidate) begin
                    if (hitAny) begin
                        takeHit = 1'b1;
                    end else begin
                        stall = 1'b1;
                        cntClear = 1'b1;
                        nextState = wayBus.victimDirty ? dcachePkg::WRITEBACK
                                                       : dcachePkg::REFILL;
                    end
                end
            end
            dcachePkg::WRITEBACK: begin
                stall = enable;
                hRequest = 1'b1;
                hWrite = 1'b1;
                useCacheAddr = 1'b1;
                wayBus.waySel = fillWay;
                wayBus.wordOff = cntValue;
                if (busReady) begin
                    // Counter wraps to zero for the refill
                    cntStep = 1'b1;
                    if (cntLast) begin
                        nextState = dcachePkg::REFILL;
                    end
                end
            end
            dcachePkg::REFILL: begin
                stall = enable;
                hRequest = 1'b1;
                fromBus = 1'b1;
                wayBus.waySel = fillWay;
                wayBus.wordOff = cntValue;
                if (busReady) begin
                    wayBus.writeEn = 1'b1;
                    cntStep = 1'b1;
                    // Tag and valid go in with the last word, line is clean
                    if (cntLast) begin
                        wayBus.lineFill = 1'b1;
                        nextState = dcachePkg::DONE;
                    end
                end
            end
            default: begin
                // Held access now hits in the refilled line
                takeHit = access && hitAny;
                nextState = dcachePkg::IDLE;
            end
        endcase

        // Completing hit, store merges and dirties the line
        if (takeHit) begin
            wayBus.writeEn = memWrite;
            wayBus.lineFill = memWrite;
            wayBus.newDirty = 1'b1;
            wayBus.lruUpdate = 1'b1;
        end

        // Disabled cache drops back to idle
        if (!enable) begin
            nextState = dcachePkg::IDLE;
        end
    end

    // Beat waiting for ready keeps request, direction and beat number
    busHeldOnWait: assert property (@(posedge clk) disable iff (!rstN)
        hRequest && !busReady && enable |=> hRequest && $stable(hWrite) && $stable(cntValue));

    // Refilled line answers the held access
    doneHits: assert property (@(posedge clk) disable iff (!rstN)
        (state == dcachePkg::DONE) && access |-> hitAny);

endmodule

//--- src/dcacheDatapath.sv
// Data cache datapath
// Store byte merge, bus address forming and read data select
`timescale 1ns/1ps

module dcacheDatapath #(
    parameter int LINES = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  dcachePkg::word_t               addr,
    input  dcachePkg::word_t               wd,
    input  dcachePkg::word_t               hrData,
    input  dcachePkg::byteMask_t           byteMask,
    input  logic                           useCacheAddr,
    input  logic                           fromBus,
    input  logic                           memWrite,
    input  logic [$clog2(BLOCK_WORDS)-1:0] cntValue,
    dcacheWayIf.data                       wayBus,
    output dcachePkg::word_t               rd,
    output dcachePkg::word_t               hAddr,
    output dcachePkg::word_t               hwData,
    output dcachePkg::word_t               mergedWord
);
    localparam int setBits = $clog2(LINES);
    localparam int offsetBits = $clog2(BLOCK_WORDS);
    localparam int tagBits = dcachePkg::WORD_BITS - setBits - offsetBits
                             - dcachePkg::BYTE_OFFSET_BITS;
    localparam int byteBits = dcachePkg::BYTE_BITS;

    logic [tagBits-1:0] addrTag;
    logic [tagBits-1:0] busTag;
    logic [setBits-1:0] addrSet;
    logic [offsetBits-1:0] addrOff;
    logic forwardWord;

    assign addrTag = addr[dcachePkg::WORD_BITS-1 -: tagBits];
    assign addrSet = addr[dcachePkg::BYTE_OFFSET_BITS + offsetBits +: setBits];
    assign addrOff = addr[dcachePkg::BYTE_OFFSET_BITS +: offsetBits];

    // Writeback goes to the victim line, refill to the requested one
    assign busTag = useCacheAddr ? wayBus.victimTag : addrTag;
    assign hAddr = {busTag, addrSet, cntValue, {dcachePkg::BYTE_OFFSET_BITS{1'b0}}};

    // Writeback data straight from the selected way
    assign hwData = wayBus.rdWord;

    // Per lane source for the way write port
    always_comb begin
        for (int b = 0; b < dcachePkg::BYTES_PER_WORD; b++) begin
            if (fromBus) begin
                mergedWord[b*byteBits +: byteBits] = hrData[b*byteBits +: byteBits];
            end else if (memWrite && byteMask[b]) begin
                mergedWord[b*byteBits +: byteBits] = wd[b*byteBits +: byteBits];
            end else begin
                mergedWord[b*byteBits +: byteBits] = wayBus.rdWord[b*byteBits +: byteBits];
            end
        end
    end

    // Requested word passing by on the bus
    assign forwardWord = fromBus && (cntValue == addrOff);

    // Bypass, forwarded bus word or cached word
    always_comb begin
        if (wayBus.bypass) begin
            rd = wd;
        end else if (forwardWord) begin
            rd = hrData;
        end else begin
            rd = wayBus.rdWord;
        end
    end

endmodule

//--- src/dcacheWayMemory.sv
// Two way storage of the data cache
// Tag, valid, dirty and word arrays with one LRU bit per set
`timescale 1ns/1ps

module dcacheWayMemory #(
    parameter int LINES = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    invalidate,
    dcacheWayIf.mem wayBus
);
    localparam int setBits = $clog2(LINES);
    localparam int offsetBits = $clog2(BLOCK_WORDS);
    localparam int tagBits = dcachePkg::WORD_BITS - setBits - offsetBits
                             - dcachePkg::BYTE_OFFSET_BITS;
    localparam int wordsPerWay = LINES * BLOCK_WORDS;

    // Per way storage
    logic [tagBits-1:0] tagMem [2][LINES];
    dcachePkg::word_t dataMem [2][wordsPerWay];
    logic [LINES-1:0] validMem [2];
    logic [LINES-1:0] dirtyMem [2];

    // Way to evict next in each set
    logic [LINES-1:0] lru;

    // Status of the addressed set
    logic [1:0] validSet;
    logic [1:0] dirtySet;
    logic victim;
    logic [setBits+offsetBits-1:0] wordIdx;

    // Word address inside one way
    assign wordIdx = {wayBus.setIdx, wayBus.wordOff};

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            validSet[w] = validMem[w][wayBus.setIdx];
            dirtySet[w] = dirtyMem[w][wayBus.setIdx];
            wayBus.hit[w] = validSet[w] && (tagMem[w][wayBus.setIdx] == wayBus.newTag);
        end
    end

    // Empty way first, else the LRU way
    assign victim = !validSet[0] ? 1'b0 :
                    !validSet[1] ? 1'b1 : lru[wayBus.setIdx];

    assign wayBus.victimWay = victim;
    // Dirty bits survive invalidate, so qualify with valid
    assign wayBus.victimDirty = validSet[victim] && dirtySet[victim];
    assign wayBus.victimTag = tagMem[victim][wayBus.setIdx];

    // Read port follows the controller's way select
    assign wayBus.rdWord = dataMem[wayBus.waySel][wordIdx];

    // Words and tags
    always_ff @(posedge clk) begin
        if (wayBus.writeEn) begin
            dataMem[wayBus.waySel][wordIdx] <= wayBus.wrData;
        end
        if (wayBus.lineFill) begin
            tagMem[wayBus.waySel][wayBus.setIdx] <= wayBus.newTag;
        end
    end

    // Line status and replacement state
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validMem <= '{default: '0};
            dirtyMem <= '{default: '0};
            lru <= '0;
        end else begin
            // Flush all lines at once, only between misses
            if (invalidate && wayBus.ctrlIdle) begin
                validMem <= '{default: '0};
            end else if (wayBus.lineFill) begin
                validMem[wayBus.waySel][wayBus.setIdx] <= wayBus.newValid;
            end
            if (wayBus.lineFill) begin
                dirtyMem[wayBus.waySel][wayBus.setIdx] <= wayBus.newDirty;
            end
            // Other way becomes least recently used
            if (wayBus.lruUpdate) begin
                lru[wayBus.setIdx] <= ~wayBus.waySel;
            end
        end
    end

endmodule

//--- src/dcacheWordCounter.sv
// Beat counter for cache line bursts
// Steps once per completed bus beat and wraps at the line size
`timescale 1ns/1ps

module dcacheWordCounter #(
    parameter int BLOCK_WORDS = 4
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           clear,
    input  logic                           step,
    output logic [$clog2(BLOCK_WORDS)-1:0] value,
    output logic                           last
);
    localparam int cntBits = $clog2(BLOCK_WORDS);
    localparam logic [cntBits-1:0] lastValue = cntBits'(BLOCK_WORDS - 1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            value <= '0;
        end else if (clear) begin
            value <= '0;
        end else if (step) begin
            // Power of two size, natural wrap
            value <= value + 1'b1;
        end
    end

    // Final word of the line
    assign last = (value == lastValue);

    // Burst start and beat end cannot coincide
    noStepOnClear: assert property (@(posedge clk) disable iff (!rstN)
        !(step && clear));

endmodule

//--- src/dcacheWayIf.sv
// Lookup and update bundle shared by the controller, the way memory
// and the datapath of the data cache
`timescale 1ns/1ps

interface dcacheWayIf #(
    parameter int LINES = 4,
    parameter int BLOCK_WORDS = 4
);
    localparam int setBits = $clog2(LINES);
    localparam int offsetBits = $clog2(BLOCK_WORDS);
    localparam int tagBits = dcachePkg::WORD_BITS - setBits - offsetBits
                             - dcachePkg::BYTE_OFFSET_BITS;

    // Controller side
    logic [setBits-1:0] setIdx;
    logic [offsetBits-1:0] wordOff;
    logic waySel;
    logic writeEn;
    logic lineFill;
    logic newValid;
    logic newDirty;
    // Also the lookup tag for the hit compare
    logic [tagBits-1:0] newTag;
    logic lruUpdate;
    logic bypass;
    logic ctrlIdle;

    // Word written into the selected way, driven by the datapath
    dcachePkg::word_t wrData;

    // Memory side
    logic [1:0] hit;
    logic victimWay;
    logic victimDirty;
    logic [tagBits-1:0] victimTag;
    dcachePkg::word_t rdWord;

    modport ctrl (
        output setIdx, wordOff, waySel, writeEn, lineFill, newValid, newDirty,
        output newTag, lruUpdate, bypass, ctrlIdle,
        input  hit, victimWay, victimDirty
    );

    modport mem (
        input  setIdx, wordOff, waySel, writeEn, lineFill, newValid, newDirty,
        input  newTag, lruUpdate, ctrlIdle, wrData,
        output hit, victimWay, victimDirty, victimTag, rdWord
    );

    modport data (
        input rdWord, victimTag, bypass
    );

endinterface

//--- src/dcachePkg.sv
// Data cache shared definitions
// Word types, miss FSM states and fixed widths

package dcachePkg;

    // Fixed data path widths
    localparam int WORD_BITS = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_BITS = 8;

    // Low address bits that pick a byte inside a word
    localparam int BYTE_OFFSET_BITS = 2;

    // One data or address word
    typedef logic [WORD_BITS-1:0] word_t;

    // Byte lane enables of a store
    typedef logic [BYTES_PER_WORD-1:0] byteMask_t;

    // Miss handling sequence
    // DONE is the single cycle in which the held access finishes as a hit
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        DONE
    } ctrlState_t;

endpackage
